/* include/csr_settings.svh */
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// word widths
`define CSR_DATA_W 32
`define CSR_TIMER_W 32

// external interrupt lines, bit 8 is the inter-core one
`define CSR_HWI_W 9

// crmd holds plv, ie, da, pg, datf, datm
`define CSR_CRMD_W 9
`define CSR_CRMD_RST 8

// eentry is 64-byte aligned
`define CSR_EENTRY_LSB 6

`endif

/* rtl/csr_map_pkg.sv */
package csr_map_pkg;

    // architectural csr numbers kept in this unit
    typedef enum logic [13:0] {
        CRMD   = 14'h000,
        PRMD   = 14'h001,
        ECFG   = 14'h004,
        ESTAT  = 14'h005,
        ERA    = 14'h006,
        BADV   = 14'h007,
        EENTRY = 14'h00c,
        SAVE0  = 14'h030,
        SAVE1  = 14'h031,
        SAVE2  = 14'h032,
        SAVE3  = 14'h033,
        TID    = 14'h040,
        TCFG   = 14'h041,
        TVAL   = 14'h042,
        TICLR  = 14'h044
    } csr_num_e;

    // estat.ecode values
    typedef enum logic [5:0] {
        INT = 6'h00,
        ADE = 6'h08,
        ALE = 6'h09,
        SYS = 6'h0b,
        BRK = 6'h0c,
        INE = 6'h0d
    } ecode_e;

    // esubcode of an address error on instruction fetch
    localparam logic [8:0] ADEF = 9'd0;

endpackage

/* rtl/csr_op_pkg.sv */
package csr_op_pkg;

    typedef enum logic [2:0] {
        CSRRD   = 3'd0,
        CSRWR   = 3'd1,
        CSRXCHG = 3'd2,
        ERTN    = 3'd3,
        IDLE    = 3'd4,
        EXCP    = 3'd5
    } op_e;

    typedef struct packed {
        logic [1:0]            pad;
        csr_map_pkg::csr_num_e num;
    } op_csr_t;

    typedef struct packed {
        logic                pad;
        logic [8:0]          esubcode;
        csr_map_pkg::ecode_e ecode;
    } op_excp_t;

    // one argument word, csr number for csr ops, exception code for EXCP
    typedef union packed {
        op_csr_t  csr;
        op_excp_t excp;
    } op_arg_u;

    typedef enum logic {
        RUN      = 1'b0,
        WAIT_IRQ = 1'b1
    } fsm_state_e;

endpackage

/* rtl/csr_if.sv */
`timescale 1ns/1ns

`include "csr_settings.svh"

interface csr_wr_if;
    import csr_map_pkg::*;

    logic                   en;
    csr_num_e               num;
    logic [`CSR_DATA_W-1:0] data;  // already merged under the mask
    logic                   ticlr;

    modport master (output en, num, data, ticlr);
    modport slave (input en, num, data, ticlr);
endinterface

interface csr_trap_if;
    import csr_map_pkg::*;

    logic                   enter;
    logic                   ertn;
    ecode_e                 ecode;
    logic [8:0]             esubcode;
    logic [`CSR_DATA_W-1:0] era;
    logic [`CSR_DATA_W-1:0] badv;
    logic [`CSR_DATA_W-1:0] eentry;
    logic [`CSR_DATA_W-1:0] era_q;
    logic                   irq_pending;

    modport master (
        output enter, ertn, ecode, esubcode, era, badv,
        input  eentry, era_q, irq_pending
    );
    modport slave (
        input  enter, ertn, ecode, esubcode, era, badv,
        output eentry, era_q, irq_pending
    );
endinterface

/* rtl/csr_issue_fsm.sv */
`timescale 1ns/1ns

`include "csr_settings.svh"

module csr_issue_fsm (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   op_valid,
    input  csr_op_pkg::op_e        op_type,
    input  csr_op_pkg::op_arg_u    op_arg,
    input  logic [`CSR_DATA_W-1:0] op_wdata,
    input  logic [`CSR_DATA_W-1:0] op_mask,
    input  logic [`CSR_DATA_W-1:0] op_pc,
    input  logic [`CSR_DATA_W-1:0] fault_vaddr,
    input  logic                   stall,
    input  logic                   flush_in,
    input  logic [`CSR_DATA_W-1:0] rd_value,
    output csr_map_pkg::csr_num_e  rd_num,
    output logic [`CSR_DATA_W-1:0] rdata,
    output logic                   redirect,
    output logic [`CSR_DATA_W-1:0] redirect_pc,
    output logic                   excp_flush,
    output logic                   ertn_flush,
    output logic                   clk_stall,
    csr_wr_if.master               wr,
    csr_trap_if.master             trap
);
    import csr_map_pkg::*;
    import csr_op_pkg::*;

    fsm_state_e             state;
    logic [`CSR_DATA_W-1:0] idle_pc;
    logic                   take_int;
    logic                   accept;
    logic                   csr_op;
    logic [`CSR_DATA_W-1:0] wmask;
    logic [`CSR_DATA_W-1:0] merged;

    assign rd_num = op_arg.csr.num;

    // no second interrupt while the entry is still committing
    assign take_int = trap.irq_pending && !trap.enter;
    assign accept   = state == RUN && op_valid && !stall && !flush_in && !take_int;
    assign csr_op   = op_type == CSRWR || op_type == CSRXCHG;
    assign wmask    = (op_type == CSRXCHG) ? op_mask : '1;
    assign merged   = (rd_value & ~wmask) | (op_wdata & wmask);

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            state      <= RUN;
            clk_stall  <= 1'b0;
            redirect   <= 1'b0;
            excp_flush <= 1'b0;
            ertn_flush <= 1'b0;
            wr.en      <= 1'b0;
            wr.ticlr   <= 1'b0;
            trap.enter <= 1'b0;
            trap.ertn  <= 1'b0;
        end
        else
        begin
            excp_flush <= trap.enter;  // one cycle after the commit
            ertn_flush <= trap.ertn;
            redirect   <= take_int || (accept && (op_type == EXCP || op_type == ERTN));
            wr.en      <= accept && csr_op;
            wr.ticlr   <= accept && csr_op && op_arg.csr.num == TICLR && merged[0];
            trap.enter <= take_int || (accept && op_type == EXCP);
            trap.ertn  <= accept && op_type == ERTN;
            if (take_int)
            begin
                state     <= RUN;
                clk_stall <= 1'b0;
            end
            else if (accept && op_type == IDLE)
            begin
                state     <= WAIT_IRQ;
                clk_stall <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            rdata   <= rd_value;  // old value, before any commit
            wr.num  <= op_arg.csr.num;
            wr.data <= merged;
        end
        if (take_int || (accept && op_type == EXCP))
            redirect_pc <= trap.eentry;
        else if (accept && op_type == ERTN)
            redirect_pc <= trap.era_q;
        if (accept && op_type == IDLE)
            idle_pc <= op_pc + 32'd4;
        if (take_int)
        begin
            trap.ecode    <= INT;
            trap.esubcode <= '0;
            trap.era      <= (state == WAIT_IRQ) ? idle_pc : op_pc;
        end
        else if (accept)
        begin
            trap.ecode    <= op_arg.excp.ecode;
            trap.esubcode <= op_arg.excp.esubcode;
            trap.era      <= op_pc;
            trap.badv     <= fault_vaddr;
        end
    end

endmodule

/* rtl/csr_timer.sv */
`timescale 1ns/1ns

`include "csr_settings.svh"

module csr_timer (
    input  logic                    clk,
    input  logic                    rstn,
    output logic                    ti,
    output logic [`CSR_TIMER_W-1:0] tcfg,
    output logic [`CSR_TIMER_W-1:0] tval,
    csr_wr_if.slave                 wr
);
    import csr_map_pkg::*;

    logic en;
    logic periodic;
    logic en_d;
    logic load;

    assign en       = tcfg[0];
    assign periodic = tcfg[1];

    // first cycle after en rises, or periodic wrap at zero
    assign load = (en && !en_d) || (en && en_d && periodic && tval == '0);

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tcfg <= '0;
            tval <= '0;
            en_d <= 1'b0;
            ti   <= 1'b0;
        end
        else
        begin
            en_d <= en;
            if (wr.en && wr.num == TCFG)
                tcfg <= wr.data[`CSR_TIMER_W-1:0];

            if (wr.ticlr)
                ti <= 1'b0;
            else if (en && en_d && tval == '0)
                ti <= 1'b1;

            if (load)
                tval <= {tcfg[`CSR_TIMER_W-1:2], 2'b00};
            else if (!en && en_d)
                tval <= '0;
            else if (en && tval != '1)
                tval <= tval - 1'b1;  // one-shot stops after passing zero
        end
    end

endmodule

/* rtl/csr_regfile.sv */
`timescale 1ns/1ns

`include "csr_settings.svh"

module csr_regfile (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic [`CSR_HWI_W-1:0]   hw_int,
    input  logic                    ti,
    input  logic [`CSR_TIMER_W-1:0] tcfg,
    input  logic [`CSR_TIMER_W-1:0] tval,
    input  csr_map_pkg::csr_num_e   rd_num,
    output logic [`CSR_DATA_W-1:0]  rd_value,
    output logic [`CSR_CRMD_W-1:0]  crmd,
    csr_wr_if.slave                 wr,
    csr_trap_if.slave               trap
);
    import csr_map_pkg::*;

    logic [`CSR_CRMD_W-1:0]                 crmd_q;
    logic [2:0]                             prmd_q;  // pplv, pie
    logic [12:0]                            ecfg_lie;
    logic [1:0]                             is_sw;
    ecode_e                                 ecode_q;
    logic [8:0]                             esubcode_q;
    logic [`CSR_DATA_W-1:0]                 era_q;
    logic [`CSR_DATA_W-1:0]                 badv_q;
    logic [`CSR_DATA_W-1:`CSR_EENTRY_LSB]   eentry_q;
    logic [`CSR_DATA_W-1:0]                 save_q [4];
    logic [`CSR_DATA_W-1:0]                 tid_q;
    logic [12:0]                            int_bits;
    logic [`CSR_DATA_W-1:0]                 estat;

    assign crmd     = crmd_q;
    assign int_bits = {hw_int[8], ti, 1'b0, hw_int[7:0], is_sw};
    assign estat    = {1'b0, esubcode_q, ecode_q, 3'b000, int_bits};

    assign trap.eentry      = {eentry_q, {`CSR_EENTRY_LSB{1'b0}}};
    assign trap.era_q       = era_q;
    assign trap.irq_pending = |(int_bits & ecfg_lie) && crmd_q[2];

    always_comb
    begin
        case (rd_num)
            CRMD:    rd_value = {{(`CSR_DATA_W-`CSR_CRMD_W){1'b0}}, crmd_q};
            PRMD:    rd_value = {29'b0, prmd_q};
            ECFG:    rd_value = {19'b0, ecfg_lie};
            ESTAT:   rd_value = estat;
            ERA:     rd_value = era_q;
            BADV:    rd_value = badv_q;
            EENTRY:  rd_value = trap.eentry;
            SAVE0:   rd_value = save_q[0];
            SAVE1:   rd_value = save_q[1];
            SAVE2:   rd_value = save_q[2];
            SAVE3:   rd_value = save_q[3];
            TID:     rd_value = tid_q;
            TCFG:    rd_value = tcfg;
            TVAL:    rd_value = tval;
            default: rd_value = '0;  // ticlr reads as zero
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd_q     <= `CSR_CRMD_W'(`CSR_CRMD_RST);
            prmd_q     <= '0;
            ecfg_lie   <= '0;
            is_sw      <= '0;
            ecode_q    <= INT;
            esubcode_q <= '0;
            era_q      <= '0;
            badv_q     <= '0;
            eentry_q   <= '0;
            for (int i = 0; i < 4; i++)
                save_q[i] <= '0;
            tid_q      <= '0;
        end
        else if (trap.enter)
        begin
            prmd_q      <= crmd_q[2:0];
            crmd_q[2:0] <= 3'b000;
            era_q       <= trap.era;
            ecode_q     <= trap.ecode;
            esubcode_q  <= trap.esubcode;
            if (trap.ecode == ALE || (trap.ecode == ADE && trap.esubcode == ADEF))
                badv_q <= trap.badv;
        end
        else if (trap.ertn)
            crmd_q[2:0] <= prmd_q;
        else if (wr.en)
        begin
            case (wr.num)
                CRMD:   crmd_q   <= wr.data[`CSR_CRMD_W-1:0];
                PRMD:   prmd_q   <= wr.data[2:0];
                ECFG:   ecfg_lie <= wr.data[12:0] & 13'h1bff;  // bit 10 reserved
                ESTAT:  is_sw    <= wr.data[1:0];
                ERA:    era_q    <= wr.data;
                BADV:   badv_q   <= wr.data;
                EENTRY: eentry_q <= wr.data[`CSR_DATA_W-1:`CSR_EENTRY_LSB];
                SAVE0:  save_q[0] <= wr.data;
                SAVE1:  save_q[1] <= wr.data;
                SAVE2:  save_q[2] <= wr.data;
                SAVE3:  save_q[3] <= wr.data;
                TID:    tid_q    <= wr.data;
                default: ;  // timer registers live in csr_timer
            endcase
        end
    end

endmodule

/* rtl/csr_top.sv */
`timescale 1ns/1ns

`include "csr_settings.svh"

module csr_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   op_valid,
    input  csr_op_pkg::op_e        op_type,
    input  csr_op_pkg::op_arg_u    op_arg,
    input  logic [`CSR_DATA_W-1:0] op_wdata,
    input  logic [`CSR_DATA_W-1:0] op_mask,
    input  logic [`CSR_DATA_W-1:0] op_pc,
    input  logic [`CSR_DATA_W-1:0] fault_vaddr,
    input  logic [`CSR_HWI_W-1:0]  hw_int,
    input  logic                   stall,
    input  logic                   flush_in,
    output logic [`CSR_DATA_W-1:0] rdata,
    output logic                   redirect,
    output logic [`CSR_DATA_W-1:0] redirect_pc,
    output logic                   excp_flush,
    output logic                   ertn_flush,
    output logic                   clk_stall,
    output logic [`CSR_CRMD_W-1:0] crmd
);
    import csr_map_pkg::*;

    csr_num_e                rd_num;
    logic [`CSR_DATA_W-1:0]  rd_value;
    logic                    ti;
    logic [`CSR_TIMER_W-1:0] tcfg;
    logic [`CSR_TIMER_W-1:0] tval;

    csr_wr_if   wr_bus ();
    csr_trap_if trap_bus ();

    csr_issue_fsm u_fsm (
        .clk         (clk),
        .rstn        (rstn),
        .op_valid    (op_valid),
        .op_type     (op_type),
        .op_arg      (op_arg),
        .op_wdata    (op_wdata),
        .op_mask     (op_mask),
        .op_pc       (op_pc),
        .fault_vaddr (fault_vaddr),
        .stall       (stall),
        .flush_in    (flush_in),
        .rd_value    (rd_value),
        .rd_num      (rd_num),
        .rdata       (rdata),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .excp_flush  (excp_flush),
        .ertn_flush  (ertn_flush),
        .clk_stall   (clk_stall),
        .wr          (wr_bus.master),
        .trap        (trap_bus.master)
    );

    csr_regfile u_regfile (
        .clk      (clk),
        .rstn     (rstn),
        .hw_int   (hw_int),
        .ti       (ti),
        .tcfg     (tcfg),
        .tval     (tval),
        .rd_num   (rd_num),
        .rd_value (rd_value),
        .crmd     (crmd),
        .wr       (wr_bus.slave),
        .trap     (trap_bus.slave)
    );

    csr_timer u_timer (
        .clk  (clk),
        .rstn (rstn),
        .ti   (ti),
        .tcfg (tcfg),
        .tval (tval),
        .wr   (wr_bus.slave)
    );

endmodule

/* tests/csr_tb.sv */
`timescale 1ns/1ns

`include "csr_settings.svh"

module csr_tb;
    import csr_map_pkg::*;
    import csr_op_pkg::*;

    typedef struct packed {
        op_e         op;
        logic [15:0] arg;
        logic [31:0] wdata;
        logic [31:0] mask;
        logic [31:0] pc;
        logic [31:0] vaddr;
        logic [31:0] exp_rdata;
        logic [31:0] exp_pc;
        logic [8:0]  exp_crmd;
        logic [1:0]  flush;  // 0 none, 1 exception, 2 return
        logic        stl;
    } entry_t;

    logic                   clk;
    logic                   rstn;
    logic                   op_valid;
    op_e                    op_type;
    logic [15:0]            op_arg;
    logic [`CSR_DATA_W-1:0] op_wdata;
    logic [`CSR_DATA_W-1:0] op_mask;
    logic [`CSR_DATA_W-1:0] op_pc;
    logic [`CSR_DATA_W-1:0] fault_vaddr;
    logic [`CSR_HWI_W-1:0]  hw_int;
    logic                   stall;
    logic                   flush_in;
    logic [`CSR_DATA_W-1:0] rdata;
    logic                   redirect;
    logic [`CSR_DATA_W-1:0] redirect_pc;
    logic                   excp_flush;
    logic                   ertn_flush;
    logic                   clk_stall;
    logic [`CSR_CRMD_W-1:0] crmd;

    entry_t      table_q[$];
    logic [31:0] model [0:127];  // indexed by csr number
    logic        ti_m;
    logic [31:0] lcg_state;
    logic [31:0] wait_pc;
    logic [31:0] idle_pc;

    csr_top dut (
        .clk(clk), .rstn(rstn), .op_valid(op_valid), .op_type(op_type), .op_arg(op_arg),
        .op_wdata(op_wdata), .op_mask(op_mask), .op_pc(op_pc), .fault_vaddr(fault_vaddr),
        .hw_int(hw_int), .stall(stall), .flush_in(flush_in), .rdata(rdata),
        .redirect(redirect), .redirect_pc(redirect_pc), .excp_flush(excp_flush),
        .ertn_flush(ertn_flush), .clk_stall(clk_stall), .crmd(crmd)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp)
        begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] read_model(input logic [13:0] num);
        logic [31:0] v;
        v = (num == TICLR) ? 32'h0 : model[num];
        if (num == ESTAT)
            v = v | {19'b0, hw_int[8], ti_m, 1'b0, hw_int[7:0], 2'b00};  // live interrupt lines
        return v;
    endfunction

    task write_model(input logic [13:0] num, input logic [31:0] d);
        case (num)
            CRMD:    model[CRMD] = d & 32'h1ff;
            PRMD:    model[PRMD] = d & 32'h7;
            ECFG:    model[ECFG] = d & 32'h1bff;
            ESTAT:   model[ESTAT] = (model[ESTAT] & ~32'h3) | (d & 32'h3);
            EENTRY:  model[EENTRY] = d & ~32'h3f;
            TICLR:   if (d[0]) ti_m = 1'b0;
            TVAL:    ;
            default: model[num] = d;
        endcase
    endtask

    task enter_trap(input logic [5:0] code, input logic [8:0] esub, input logic [31:0] era);
        model[PRMD] = model[CRMD] & 32'h7;
        model[CRMD] = model[CRMD] & ~32'h7;
        model[ERA] = era;
        model[ESTAT] = {1'b0, esub, code, 14'b0, model[ESTAT][1:0]};
    endtask

    task add_op(input op_e op, input logic [15:0] arg, input logic [31:0] wdata, mask, pc,
                vaddr, input logic stl);
        entry_t      e;
        logic [31:0] old;
        old = read_model(arg[13:0]);
        e.op = op;
        e.arg = arg;
        e.wdata = wdata;
        e.mask = mask;
        e.pc = pc;
        e.vaddr = vaddr;
        e.stl = stl;
        e.exp_rdata = old;
        e.exp_pc = 32'h0;
        e.flush = 2'd0;
        if (!stl && op == CSRWR)
            write_model(arg[13:0], wdata);
        else if (!stl && op == CSRXCHG)
            write_model(arg[13:0], (old & ~mask) | (wdata & mask));
        else if (!stl && op == EXCP)
        begin
            e.flush = 2'd1;
            e.exp_pc = model[EENTRY];
            if (arg[5:0] == ALE)
                model[BADV] = vaddr;
            enter_trap(arg[5:0], arg[14:6], pc);
        end
        else if (!stl && op == ERTN)
        begin
            e.flush = 2'd2;
            e.exp_pc = model[ERA];
            model[CRMD] = (model[CRMD] & ~32'h7) | model[PRMD];
        end
        e.exp_crmd = model[CRMD][8:0];
        table_q.push_back(e);
    endtask

    task add_csr(input op_e op, input csr_num_e num, input logic [31:0] wdata, mask);
        add_op(op, {2'b00, num}, wdata, mask, 32'h0, 32'h0, 1'b0);
    endtask

    task add_trap(input op_e op, input ecode_e code, input logic [31:0] pc, vaddr);
        add_op(op, {1'b0, 9'd0, code}, 32'h0, 32'h0, pc, vaddr, 1'b0);
    endtask

    // one op cycle then one idle cycle
    task apply_entry(input entry_t e);
        op_valid = 1'b1;
        op_type = e.op;
        op_arg = e.arg;
        op_wdata = e.wdata;
        op_mask = e.mask;
        op_pc = e.pc;
        fault_vaddr = e.vaddr;
        stall = e.stl;
        @(posedge clk);
        #1;
        if (!e.stl && (e.op == CSRRD || e.op == CSRWR || e.op == CSRXCHG))
            check_value(rdata, e.exp_rdata, "rdata");
        check_value(redirect, e.flush != 2'd0, "redirect");
        if (e.flush != 2'd0)
            check_value(redirect_pc, e.exp_pc, "redirect_pc");
        check_value(clk_stall, !e.stl && e.op == IDLE, "clk_stall");
        check_value({excp_flush, ertn_flush}, 32'h0, "flush before commit");
        op_valid = 1'b0;
        stall = 1'b0;
        @(posedge clk);
        #1;
        check_value(excp_flush, e.flush == 2'd1, "excp_flush");
        check_value(ertn_flush, e.flush == 2'd2, "ertn_flush");
        check_value(crmd, e.exp_crmd, "crmd");
    endtask

    task run_table();
        entry_t e;
        while (table_q.size() > 0)
        begin
            e = table_q.pop_front();
            apply_entry(e);
        end
    endtask

    task wait_flush(input int limit, input string what);
        int n;
        n = 0;
        while (excp_flush !== 1'b1)
        begin
            if (n == limit)
            begin
                $display("Timeout: no exception flush seen while waiting for %s", what);
                $display("Some tests failed");
                $fatal(1);
            end
            n++;
            @(posedge clk);
            #1;
        end
    endtask

    initial
    begin
        for (int i = 0; i < 128; i++)
            model[i] = 32'h0;
        model[CRMD] = `CSR_CRMD_RST;
        ti_m = 1'b0;
        lcg_state = 32'd20630;
        rstn = 1'b0;
        op_valid = 1'b0;
        op_type = CSRRD;
        op_arg = 16'h0;
        op_wdata = 32'h0;
        op_mask = 32'h0;
        op_pc = 32'h0;
        fault_vaddr = 32'h0;
        hw_int = 9'h0a5;  // lie stays zero, so no interrupt
        stall = 1'b0;
        flush_in = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;

        add_csr(CSRRD, CRMD, 32'h0, 32'h0);
        add_csr(CSRRD, ESTAT, 32'h0, 32'h0);
        for (int i = 0; i < 4; i++)
            add_csr(CSRWR, csr_num_e'(SAVE0 + i), next_rand(), 32'h0);
        add_csr(CSRWR, EENTRY, next_rand(), 32'h0);
        add_csr(CSRWR, TID, next_rand(), 32'h0);
        for (int i = 0; i < 4; i++)
            add_csr(CSRRD, csr_num_e'(SAVE0 + i), 32'h0, 32'h0);
        add_csr(CSRRD, EENTRY, 32'h0, 32'h0);
        add_csr(CSRRD, TID, 32'h0, 32'h0);
        add_csr(CSRXCHG, SAVE1, next_rand(), next_rand());
        add_csr(CSRRD, SAVE1, 32'h0, 32'h0);
        add_op(CSRWR, {2'b00, SAVE2}, next_rand(), 32'h0, 32'h0, 32'h0, 1'b1);
        add_csr(CSRRD, SAVE2, 32'h0, 32'h0);
        add_csr(CSRWR, CRMD, 32'h0f, 32'h0);  // plv 3, ie set
        add_trap(EXCP, SYS, next_rand() & ~32'h3, next_rand());
        add_csr(CSRRD, ERA, 32'h0, 32'h0);
        add_csr(CSRRD, ESTAT, 32'h0, 32'h0);
        add_csr(CSRRD, PRMD, 32'h0, 32'h0);
        add_csr(CSRRD, BADV, 32'h0, 32'h0);
        add_trap(ERTN, INT, 32'h0, 32'h0);
        add_trap(EXCP, ALE, next_rand() & ~32'h3, next_rand());
        add_csr(CSRRD, BADV, 32'h0, 32'h0);
        add_csr(CSRRD, ESTAT, 32'h0, 32'h0);
        add_trap(ERTN, INT, 32'h0, 32'h0);
        run_table();

        // one-shot timer interrupt through lie bit 11
        add_csr(CSRWR, ECFG, 32'h800, 32'h0);
        add_csr(CSRWR, CRMD, 32'h0c, 32'h0);
        add_csr(CSRWR, TCFG, 32'h11, 32'h0);
        run_table();
        wait_pc = next_rand() & ~32'h3;
        op_pc = wait_pc;
        wait_flush(100, "timer interrupt");
        check_value(redirect_pc, model[EENTRY], "timer redirect_pc");
        enter_trap(INT, 9'd0, wait_pc);
        ti_m = 1'b1;
        check_value(crmd, model[CRMD][8:0], "crmd after timer interrupt");
        add_csr(CSRRD, ESTAT, 32'h0, 32'h0);
        add_csr(CSRRD, ERA, 32'h0, 32'h0);
        add_csr(CSRRD, PRMD, 32'h0, 32'h0);
        add_csr(CSRWR, TICLR, 32'h1, 32'h0);
        add_csr(CSRRD, ESTAT, 32'h0, 32'h0);
        add_csr(CSRWR, TCFG, 32'h0, 32'h0);
        run_table();

        // idle until hw_int[0]
        hw_int = 9'h000;
        idle_pc = next_rand() & ~32'h3;
        add_csr(CSRWR, ECFG, 32'h4, 32'h0);
        add_csr(CSRWR, CRMD, 32'h0c, 32'h0);
        add_trap(IDLE, INT, idle_pc, 32'h0);
        run_table();
        repeat (4)
        begin
            @(posedge clk);
            #1;
            check_value(clk_stall, 1'b1, "clk_stall while idle");
            check_value(excp_flush, 1'b0, "excp_flush while idle");
        end
        hw_int = 9'h001;
        wait_flush(20, "idle wakeup");
        check_value(clk_stall, 1'b0, "clk_stall after wakeup");
        check_value(redirect_pc, model[EENTRY], "wakeup redirect_pc");
        enter_trap(INT, 9'd0, idle_pc + 32'd4);
        add_csr(CSRRD, ERA, 32'h0, 32'h0);
        add_csr(CSRRD, ESTAT, 32'h0, 32'h0);
        add_csr(CSRRD, PRMD, 32'h0, 32'h0);
        add_csr(CSRRD, CRMD, 32'h0, 32'h0);
        run_table();

        $display("All tests passed");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+include
rtl/csr_map_pkg.sv
rtl/csr_op_pkg.sv
rtl/csr_if.sv
rtl/csr_issue_fsm.sv
rtl/csr_timer.sv
rtl/csr_regfile.sv
rtl/csr_top.sv
tests/csr_tb.sv

/* Bender.yml */
package:
  name: csr_unit

export_include_dirs:
  - include

sources:
  - rtl/csr_map_pkg.sv
  - rtl/csr_op_pkg.sv
  - rtl/csr_if.sv
  - rtl/csr_issue_fsm.sv
  - rtl/csr_timer.sv
  - rtl/csr_regfile.sv
  - rtl/csr_top.sv
  - target: test
    files:
      - tests/csr_tb.sv
